// File: list.f
relay_pkg.sv
fifo.sv
ingress_stage.sv
tag_stage.sv
egress_stage.sv
relay_top.sv
relay_checker.sv
tb_relay.sv

// File: run.sh
#!/bin/sh
# build and run the relay testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_relay -o tb_relay \
	> build.log 2>&1 \
	&& ./obj_dir/tb_relay > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: no result line"; exit 1; }
echo "PASS"
exit 0

// File: tb_relay.sv
// tb_relay
// testbench top for the credit-flow relay
// lfsr stimulus, upstream credit model, delayed downstream credit return

`timescale 1ns/100ps
`default_nettype none

module tb_relay;

	import relay_pkg::*;

	// ----------------------------------------------------------------------
	// run sizing
	// ----------------------------------------------------------------------
	localparam int FREE_WORDS  = 40;
	localparam int STALL_WORDS = IN_DEPTH + OUT_DEPTH + OUT_CREDITS;
	localparam int LONG_WORDS  = 300;
	localparam int TOTAL_WORDS = FREE_WORDS + STALL_WORDS + LONG_WORDS;
	localparam int TIMEOUT     = 4 * TOTAL_WORDS + 200;
	localparam int STALL_LEN   = 60;

	logic  clk = 1'b0;
	logic  rst;
	logic  in_valid;
	data_t in_data;
	logic  in_credit;
	logic  out_valid;
	flit_t out_flit;
	logic  out_credit;

	// monitor results
	int chk_errors;
	int chk_flits;
	int chk_up;

	// stimulus state
	logic [31:0] lfsr;
	int up_credits;
	int sent;
	int tick;
	int tb_errors;
	int cycles = 0;
	int due_q[$];
	int first_sent;
	int stall_mark;

	always #2 clk = ~clk;

	relay_top relay_top_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_credit (in_credit),
		.out_valid (out_valid),
		.out_flit  (out_flit),
		.out_credit(out_credit)
	);

	relay_checker relay_checker_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_credit (in_credit),
		.out_valid (out_valid),
		.out_flit  (out_flit),
		.out_credit(out_credit),
		.errors    (chk_errors),
		.flits     (chk_flits),
		.up_credits(chk_up)
	);

	// ----------------------------------------------------------------------
	// random source
	// ----------------------------------------------------------------------
	// right-shift galois lfsr, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// ----------------------------------------------------------------------
	// one clock of upstream and downstream agents
	// ----------------------------------------------------------------------
	task automatic drive_cycle(input logic may_send, input logic hold, input int rate_bits);
		@(posedge clk);
		tick++;
		in_valid   <= 1'b0;
		out_credit <= 1'b0;
		if (in_credit) begin
			up_credits++;
		end
		// each received flit owes one credit after 0..3 cycles
		if (out_valid) begin
			due_q.push_back(tick + int'(take_bits(2)));
		end
		if (!hold && due_q.size() > 0 && due_q[0] <= tick) begin
			out_credit <= 1'b1;
			void'(due_q.pop_front());
		end
		// send only with a credit in hand
		if (may_send && up_credits > 0 && take_bits(rate_bits) != 0) begin
			in_valid <= 1'b1;
			in_data  <= take_bits(32);
			up_credits--;
			sent++;
		end
	endtask

	task automatic send_words(input int count, input int rate_bits);
		int target;
		target = sent + count;
		while (sent < target) begin
			drive_cycle(1'b1, 1'b0, rate_bits);
		end
	endtask

	// idle until every word is out and every credit is home
	task automatic drain();
		while (chk_flits != sent || up_credits != IN_DEPTH || due_q.size() != 0) begin
			drive_cycle(1'b0, 1'b0, 1);
		end
	endtask

	task automatic report_phase(input string name, input int words);
		$display("phase %s done: %0d words, %0d flits checked, %0d errors",
			name, words, chk_flits, chk_errors + tb_errors);
	endtask

	// ----------------------------------------------------------------------
	// run limit
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: run still busy after %0d cycles", TIMEOUT);
			$display("Finished with errors");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// phases
	// ----------------------------------------------------------------------
	initial begin
		rst        = 1'b1;
		in_valid   = 1'b0;
		in_data    = '0;
		out_credit = 1'b0;
		lfsr       = 32'h954b_a0dd;
		up_credits = IN_DEPTH;
		sent       = 0;
		tick       = 0;
		tb_errors  = 0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// free flow, three sends in four
		first_sent = sent;
		send_words(FREE_WORDS, 2);
		drain();
		report_phase("free flow", sent - first_sent);

		// downstream credits held back, relay must fill and stop
		first_sent = sent;
		for (int i = 0; i < STALL_LEN; i++) begin
			if (i == STALL_LEN / 2) begin
				stall_mark = chk_flits;
			end
			drive_cycle(1'b1, 1'b1, 2);
		end
		if (chk_flits != stall_mark) begin
			tb_errors++;
			$display("stall: flits kept leaving while downstream credits were held back");
		end
		drain();
		report_phase("stall", sent - first_sent);

		// long run, crosses the seq wrap
		first_sent = sent;
		send_words(LONG_WORDS, 1);
		drain();
		report_phase("long run", sent - first_sent);

		// monitor's own credit count must be back at full
		repeat (2) @(posedge clk);
		if (chk_up != IN_DEPTH) begin
			tb_errors++;
			$display("error at %0t: upstream credits %0d after drain, expected %0d",
				$time, chk_up, IN_DEPTH);
		end

		$display("total: %0d words sent, %0d flits checked, %0d errors",
			sent, chk_flits, chk_errors + tb_errors);
		if (chk_errors + tb_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: relay_checker.sv
// relay_checker
// testbench monitor for the credit-flow relay
// models sent words, sequence stamps, parity and both credit loops

`timescale 1ns/100ps
`default_nettype none

module relay_checker (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             in_valid,
	input  wire relay_pkg::data_t in_data,
	input  wire logic             in_credit,
	input  wire logic             out_valid,
	input  wire relay_pkg::flit_t out_flit,
	input  wire logic             out_credit,
	output int                    errors,
	output int                    flits,
	output int                    up_credits
);

	import relay_pkg::*;

	// words sent but not yet seen at the output
	data_t sent_q[$];
	data_t exp_data;
	seq_t  exp_seq;
	logic  exp_parity;

	// model state kept here and copied to the ports every edge
	int n_err     = 0;
	int n_flits   = 0;
	int n_up      = IN_DEPTH;
	int n_out     = 0;
	int n_granted = 0;

	initial begin
		errors     = 0;
		flits      = 0;
		up_credits = IN_DEPTH;
	end

	always @(posedge clk) begin
		if (rst) begin
			// nothing may leave the relay while in reset
			if (out_valid || in_credit) begin
				n_err++;
				$display("error at %0t: out_valid=%0b in_credit=%0b during reset",
					$time, out_valid, in_credit);
			end
			sent_q.delete();
			exp_seq   = '0;
			n_up      = IN_DEPTH;
			n_out     = 0;
			n_granted = 0;
		end else begin
			// ----------------------------------------------------------------
			// upstream side
			// ----------------------------------------------------------------
			if (in_valid) begin
				sent_q.push_back(in_data);
				n_up--;
			end
			if (in_credit) begin
				n_up++;
				if (n_up > IN_DEPTH) begin
					n_err++;
					$display("error at %0t: upstream credits rose to %0d, limit %0d",
						$time, n_up, IN_DEPTH);
				end
			end
			// ----------------------------------------------------------------
			// downstream side
			// ----------------------------------------------------------------
			if (out_credit) begin
				n_granted++;
			end
			if (out_valid) begin
				n_out++;
				// never more flits than initial credits plus returns
				if (n_out > OUT_CREDITS + n_granted) begin
					n_err++;
					$display("error at %0t: %0d flits sent with only %0d credits",
						$time, n_out, OUT_CREDITS + n_granted);
				end
				if (sent_q.size() == 0) begin
					n_err++;
					$display("error at %0t: flit %h with no word outstanding",
						$time, out_flit);
				end else begin
					exp_data = sent_q.pop_front();
					if (out_flit.data !== exp_data) begin
						n_err++;
						$display("error at %0t: data %h, expected %h",
							$time, out_flit.data, exp_data);
					end
					// even parity over the expected seq and data
					exp_parity = ^{exp_seq, exp_data};
					if (out_flit.parity !== exp_parity) begin
						n_err++;
						$display("error at %0t: parity %0b, expected %0b",
							$time, out_flit.parity, exp_parity);
					end
				end
				if (out_flit.seq !== exp_seq) begin
					n_err++;
					$display("error at %0t: seq %0d, expected %0d",
						$time, out_flit.seq, exp_seq);
				end
				// 255 rolls over to 0
				exp_seq = exp_seq + 8'd1;
				n_flits++;
			end
		end
		errors     <= n_err;
		flits      <= n_flits;
		up_credits <= n_up;
	end

endmodule

`default_nettype wire

// File: relay_top.sv
// relay_top
// credit-flow word relay
// ingress buffer, then sequence/parity stamp, then credited egress

`timescale 1ns/100ps
`default_nettype none

module relay_top (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             in_valid,
	input  wire relay_pkg::data_t in_data,
	output logic                  in_credit,
	output logic                  out_valid,
	output relay_pkg::flit_t      out_flit,
	input  wire logic             out_credit
);

	import relay_pkg::*;

	// ingress to tag
	data_t head_data;
	logic  head_empty;
	logic  pop;

	// tag to egress
	logic  tag_wr;
	flit_t tag_flit;
	logic  egress_full;

	// ----------------------------------------------------------------------
	// stage chain
	// ----------------------------------------------------------------------
	ingress_stage ingress_stage_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.pop       (pop),
		.head_data (head_data),
		.head_empty(head_empty),
		.in_credit (in_credit)
	);

	tag_stage tag_stage_i (
		.clk        (clk),
		.rst        (rst),
		.head_data  (head_data),
		.head_empty (head_empty),
		.egress_full(egress_full),
		.pop        (pop),
		.tag_wr     (tag_wr),
		.tag_flit   (tag_flit)
	);

	egress_stage egress_stage_i (
		.clk        (clk),
		.rst        (rst),
		.tag_wr     (tag_wr),
		.tag_flit   (tag_flit),
		.out_credit (out_credit),
		.egress_full(egress_full),
		.out_valid  (out_valid),
		.out_flit   (out_flit)
	);

endmodule

`default_nettype wire

// File: egress_stage.sv
// egress_stage
// holds stamped flits and sends them downstream one per credit
// credit counter starts at OUT_CREDITS, out_valid is registered

`timescale 1ns/100ps
`default_nettype none

module egress_stage (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             tag_wr,
	input  wire relay_pkg::flit_t tag_flit,
	input  wire logic             out_credit,
	output logic                  egress_full,
	output logic                  out_valid,
	output relay_pkg::flit_t      out_flit
);

	import relay_pkg::*;

	// fifo head side
	flit_t head_flit;
	logic  head_empty;

	// downstream credits held
	credit_t credits;
	// launch a flit this cycle
	logic send;

	// ----------------------------------------------------------------------
	// flit buffer
	// ----------------------------------------------------------------------
	// tag stage only writes while not full
	fifo #(
		.WIDTH($bits(flit_t)),
		.DEPTH(OUT_DEPTH)
	) fifo_i (
		.clk   (clk),
		.rst   (rst),
		.rd    (send),
		.wr    (tag_wr),
		.w_data(tag_flit),
		.empty (head_empty),
		.full  (egress_full),
		.r_data(head_flit)
	);

	// flit ready and at least one credit
	assign send = ~head_empty & (credits != '0);

	// ----------------------------------------------------------------------
	// credit counter
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credits <= credit_t'(OUT_CREDITS);
		end else begin
			case ({out_credit, send})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				// return and send cancel out
				default: credits <= credits;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// output register
	// ----------------------------------------------------------------------
	// one-cycle valid pulse per flit
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= send;
		end
	end

	// payload only loads on a send
	always_ff @(posedge clk) begin
		if (send) begin
			out_flit <= head_flit;
		end
	end

endmodule

`default_nettype wire

// File: tag_stage.sv
// tag_stage
// moves a word from the ingress head into the egress FIFO
// stamps it with a wrapping sequence number and even parity

`timescale 1ns/100ps
`default_nettype none

module tag_stage (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire relay_pkg::data_t head_data,
	input  wire logic             head_empty,
	input  wire logic             egress_full,
	output logic                  pop,
	output logic                  tag_wr,
	output relay_pkg::flit_t      tag_flit
);

	import relay_pkg::*;

	// next stamp to hand out
	seq_t seq_q;
	// a word moves this cycle
	logic xfer;

	// ----------------------------------------------------------------------
	// transfer decision
	// ----------------------------------------------------------------------
	// word waiting and room downstream
	assign xfer = ~head_empty & ~egress_full;

	// pop and write always travel together
	assign pop    = xfer;
	assign tag_wr = xfer;

	// ----------------------------------------------------------------------
	// flit build
	// ----------------------------------------------------------------------
	always_comb begin
		tag_flit.seq    = seq_q;
		tag_flit.data   = head_data;
		// xor over all 40 stamped bits
		tag_flit.parity = ^{seq_q, head_data};
	end

	// sequence counter, 255 rolls to 0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			seq_q <= '0;
		end else if (xfer) begin
			seq_q <= seq_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: ingress_stage.sv
// ingress_stage
// buffers credited upstream words in a FIFO
// returns one credit pulse upstream for every word popped

`timescale 1ns/100ps
`default_nettype none

module ingress_stage (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            in_valid,
	input  wire relay_pkg::data_t in_data,
	input  wire logic            pop,
	output relay_pkg::data_t     head_data,
	output logic                 head_empty,
	output logic                 in_credit
);

	import relay_pkg::*;

	// pop that actually removes a word
	logic pop_en;

	// ----------------------------------------------------------------------
	// word buffer
	// ----------------------------------------------------------------------
	// upstream never sends without a credit, so no overflow
	fifo #(
		.WIDTH($bits(data_t)),
		.DEPTH(IN_DEPTH)
	) fifo_i (
		.clk   (clk),
		.rst   (rst),
		.rd    (pop),
		.wr    (in_valid),
		.w_data(in_data),
		.empty (head_empty),
		.full  (),
		.r_data(head_data)
	);

	assign pop_en = pop & ~head_empty;

	// credit return, one cycle after the pop
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_credit <= 1'b0;
		end else begin
			in_credit <= pop_en;
		end
	end

endmodule

`default_nettype wire

// File: fifo.sv
// fifo
// first-word-fall-through register FIFO
// registered full/empty flags, head word shown combinationally
// DEPTH is expected to be a power of two

`timescale 1ns/100ps
`default_nettype none

module fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             rd,
	input  wire logic             wr,
	input  wire logic [WIDTH-1:0] w_data,
	output logic                  empty,
	output logic                  full,
	output logic      [WIDTH-1:0] r_data
);

	// storage
	logic [WIDTH-1:0] mem [DEPTH];

	// pointers and flags
	logic [$clog2(DEPTH)-1:0] w_ptr;
	logic [$clog2(DEPTH)-1:0] r_ptr;
	logic [$clog2(DEPTH)-1:0] w_ptr_succ;
	logic [$clog2(DEPTH)-1:0] r_ptr_succ;
	logic [$clog2(DEPTH)-1:0] w_ptr_next;
	logic [$clog2(DEPTH)-1:0] r_ptr_next;
	logic full_q;
	logic empty_q;
	logic full_next;
	logic empty_next;

	// qualified requests
	logic wr_en;
	logic rd_en;

	// write dropped when full, read dropped when empty
	assign wr_en = wr & ~full_q;
	assign rd_en = rd & ~empty_q;

	// ----------------------------------------------------------------------
	// storage array
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[w_ptr] <= w_data;
		end
	end

	// head word falls through
	assign r_data = mem[r_ptr];

	// ----------------------------------------------------------------------
	// pointer and flag control
	// ----------------------------------------------------------------------
	assign w_ptr_succ = w_ptr + 1'b1;
	assign r_ptr_succ = r_ptr + 1'b1;

	always_comb begin
		// hold by default
		w_ptr_next = w_ptr;
		r_ptr_next = r_ptr;
		full_next  = full_q;
		empty_next = empty_q;
		case ({wr_en, rd_en})
			2'b10: begin
				// write only
				w_ptr_next = w_ptr_succ;
				empty_next = 1'b0;
				if (w_ptr_succ == r_ptr) begin
					full_next = 1'b1;
				end
			end
			2'b01: begin
				// read only
				r_ptr_next = r_ptr_succ;
				full_next  = 1'b0;
				if (r_ptr_succ == w_ptr) begin
					empty_next = 1'b1;
				end
			end
			2'b11: begin
				// occupancy unchanged
				w_ptr_next = w_ptr_succ;
				r_ptr_next = r_ptr_succ;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			w_ptr   <= '0;
			r_ptr   <= '0;
			full_q  <= 1'b0;
			empty_q <= 1'b1;
		end else begin
			w_ptr   <= w_ptr_next;
			r_ptr   <= r_ptr_next;
			full_q  <= full_next;
			empty_q <= empty_next;
		end
	end

	assign full  = full_q;
	assign empty = empty_q;

endmodule

`default_nettype wire

// File: relay_pkg.sv
// relay_pkg
// shared widths, flit layout and depth/credit constants
// for the credit-flow word relay

`default_nettype none

package relay_pkg;

	// ----------------------------------------------------------------------
	// field widths
	// ----------------------------------------------------------------------
	localparam int DATA_W   = 32;
	localparam int SEQ_W    = 8;
	localparam int CREDIT_W = 4;

	// payload word from upstream
	typedef logic [DATA_W-1:0] data_t;
	// sequence stamp, wraps modulo 256
	typedef logic [SEQ_W-1:0] seq_t;
	// credit count, sized to hold the largest depth
	typedef logic [CREDIT_W-1:0] credit_t;

	// stamped flit as it leaves the relay
	// parity is even over seq and data together
	typedef struct packed {
		seq_t  seq;
		data_t data;
		logic  parity;
	} flit_t;

	// ----------------------------------------------------------------------
	// buffer depths and credits
	// ----------------------------------------------------------------------
	// ingress depth also sets the upstream's starting credits
	localparam int IN_DEPTH    = 8;
	localparam int OUT_DEPTH   = 4;
	localparam int OUT_CREDITS = 4;

endpackage

`default_nettype wire
